//--- Bender.yml
package:
  name: cpu

sources:
  - src/cpu_pkg.sv
  - src/dmem_if.sv
  - src/stage_reg.sv
  - src/word_mem.sv
  - src/fetch_unit.sv
  - src/reg_file.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/hazard_unit.sv
  - src/cpu.sv
  - target: simulation
    files:
      - sim/tb_cpu.sv

//--- sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam int CLK_PERIOD  = 8;
  localparam int DEPTH       = cpu_pkg::MEM_DEPTH;
  localparam int RANDOM_LEN  = 300;
  localparam int NUM_TESTS   = 5;
  localparam int MAX_COMMITS = 450;
  localparam int WATCHDOG_CYCLES = 40 * MAX_COMMITS + NUM_TESTS * (2 * DEPTH + 40);
  localparam logic [31:0] HALT = 32'h0000_0009; // BEQ r0, r0, 0

  typedef struct packed {
    logic [cpu_pkg::ADDR_WIDTH-1:0] pc;
    logic [31:0]                    instr;
    logic                           rd_we;
    logic [4:0]                     rd;
    logic [31:0]                    rd_data;
    logic                           st;
    logic [cpu_pkg::ADDR_WIDTH-1:0] st_addr;
    logic [31:0]                    st_data;
  } commit_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        run_i;
  logic        load_we_i;
  logic        load_dmem_i;
  logic [9:0]  load_addr_i;
  logic [31:0] load_data_i;
  logic        commit_valid_o;
  logic [9:0]  commit_pc_o;
  logic [31:0] commit_instr_o;
  logic        commit_rd_we_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_rd_data_o;
  logic        commit_st_o;
  logic [9:0]  commit_st_addr_o;
  logic [31:0] commit_st_data_o;

  logic [31:0] prog_img [0:DEPTH-1];
  logic [31:0] data_img [0:DEPTH-1];
  logic [31:0] imem_m [0:DEPTH-1]; // Reference model state
  logic [31:0] dmem_m [0:DEPTH-1];
  logic [31:0] regs_m [0:31];
  logic [9:0]  pc_m;
  int          cursor;
  int          commit_count;
  int          error_count;
  bit          checking;

  cpu i_cpu (
    .clk              (clk),
    .rst              (rst),
    .run_i            (run_i),
    .load_we_i        (load_we_i),
    .load_dmem_i      (load_dmem_i),
    .load_addr_i      (load_addr_i),
    .load_data_i      (load_data_i),
    .commit_valid_o   (commit_valid_o),
    .commit_pc_o      (commit_pc_o),
    .commit_instr_o   (commit_instr_o),
    .commit_rd_we_o   (commit_rd_we_o),
    .commit_rd_o      (commit_rd_o),
    .commit_rd_data_o (commit_rd_data_o),
    .commit_st_o      (commit_st_o),
    .commit_st_addr_o (commit_st_addr_o),
    .commit_st_data_o (commit_st_data_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_eq(input string what, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  function automatic logic [31:0] alu_op(logic [3:0] op, logic [4:0] rd, logic [4:0] ra,
                                         logic [4:0] rb);
    return {13'd0, ra, rb, rd, op};
  endfunction

  function automatic logic [31:0] mem_op(logic [3:0] op, logic [4:0] rd, logic [4:0] rb,
                                         int off);
    logic [31:0] o;
    o = off;
    return {o[17:0], rb, rd, op}; // off overlays ra and free
  endfunction

  function automatic logic [31:0] br_op(logic [3:0] op, logic [4:0] ra, logic [4:0] rb,
                                        int boff);
    logic [31:0] b;
    b = boff;
    return {b[17:5], ra, rb, b[4:0], op};
  endfunction

  function automatic logic [3:0] random_alu_op();
    case ($urandom % 5)
      0: return cpu_pkg::ADD;
      1: return cpu_pkg::SUB;
      2: return cpu_pkg::AND;
      3: return cpu_pkg::OR;
      default: return cpu_pkg::XOR;
    endcase
  endfunction

  // ISA reference, one instruction per call
  function automatic commit_t model_step();
    commit_t     c;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    logic [31:0] off;
    logic [31:0] boff;
    logic [31:0] ea;
    logic [3:0]  op;
    logic [9:0]  next_pc;
    w    = imem_m[pc_m];
    op   = w[3:0];
    a    = regs_m[w[18:14]];
    b    = regs_m[w[13:9]];
    s    = regs_m[w[8:4]];
    off  = {{14{w[31]}}, w[31:14]};
    boff = {{14{w[31]}}, w[31:19], w[8:4]};
    ea   = b + off;
    c         = '0;
    c.pc      = pc_m;
    c.instr   = w;
    c.rd      = w[8:4];
    next_pc   = pc_m + 10'd1;
    case (op)
      cpu_pkg::ADD: c.rd_data = a + b;
      cpu_pkg::SUB: c.rd_data = a - b;
      cpu_pkg::AND: c.rd_data = a & b;
      cpu_pkg::OR:  c.rd_data = a | b;
      cpu_pkg::XOR: c.rd_data = a ^ b;
      cpu_pkg::LW:  c.rd_data = dmem_m[ea[9:0]];
      cpu_pkg::SW: begin
        c.st             = 1'b1;
        c.st_addr        = ea[9:0];
        c.st_data        = s;
        dmem_m[ea[9:0]] = s;
      end
      cpu_pkg::BEQ: if (a == b) next_pc = pc_m + boff[9:0];
      cpu_pkg::BNE: if (a != b) next_pc = pc_m + boff[9:0];
      cpu_pkg::BLT: if ($signed(a) < $signed(b)) next_pc = pc_m + boff[9:0];
      cpu_pkg::BGE: if ($signed(a) >= $signed(b)) next_pc = pc_m + boff[9:0];
      cpu_pkg::JMP: next_pc = a[9:0];
      default: ; // MUL, DIV and reserved do nothing
    endcase
    c.rd_we = (op inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR,
                          cpu_pkg::XOR, cpu_pkg::LW}) && c.rd != 5'd0;
    if (c.rd_we) begin
      regs_m[c.rd] = c.rd_data;
    end
    pc_m = next_pc;
    return c;
  endfunction

  always @(negedge clk) begin : compare_commits
    commit_t exp_c;
    if (checking && commit_valid_o) begin
      exp_c = model_step();
      commit_count++;
      check_eq("commit_pc", commit_pc_o, exp_c.pc);
      check_eq("commit_instr", commit_instr_o, exp_c.instr);
      check_eq("commit_rd_we", commit_rd_we_o, exp_c.rd_we);
      check_eq("commit_rd", commit_rd_o, exp_c.rd);
      check_eq("commit_st", commit_st_o, exp_c.st);
      if (exp_c.rd_we) begin
        check_eq("commit_rd_data", commit_rd_data_o, exp_c.rd_data);
      end
      if (exp_c.st) begin
        check_eq("commit_st_addr", commit_st_addr_o, exp_c.st_addr);
        check_eq("commit_st_data", commit_st_data_o, exp_c.st_data);
      end
      if (exp_c.instr == HALT) begin
        checking = 1'b0;
      end
    end
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Error at %0t: watchdog expired, the CPU stopped committing", $time);
    $display("Regression failed");
    $fatal(1, "Watchdog timeout");
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_images();
    for (int a = 0; a < DEPTH; a++) begin
      prog_img[a] = 32'd0; // ADD r0, r0, r0
      data_img[a] = a * 32'h9E37_79B1 + 32'h1234_5678;
    end
    cursor = 0;
  endtask

  task automatic org(input int addr);
    cursor = addr;
  endtask

  task automatic emit(input logic [31:0] w);
    prog_img[cursor] = w;
    cursor++;
  endtask

  task automatic load_images();
    for (int a = 0; a < 2 * DEPTH; a++) begin
      tick();
      load_we_i   = 1'b1;
      load_dmem_i = a >= DEPTH;
      load_addr_i = 10'(a % DEPTH);
      load_data_i = (a < DEPTH) ? prog_img[a] : data_img[a - DEPTH];
    end
    tick();
    load_we_i = 1'b0;
  endtask

  task automatic run_program(input string name);
    load_images();
    for (int a = 0; a < DEPTH; a++) begin
      imem_m[a] = prog_img[a];
      dmem_m[a] = data_img[a];
    end
    for (int r = 0; r < 32; r++) begin
      regs_m[r] = 32'd0;
    end
    pc_m         = 10'd0;
    commit_count = 0;
    rst = 1'b0;
    repeat (16) tick();
    rst = 1'b1;
    repeat (4) begin
      tick();
      check_eq("commit_valid while stopped", commit_valid_o, 32'd0);
    end
    checking = 1'b1;
    tick();
    run_i = 1'b1;
    wait (!checking);
    tick();
    run_i = 1'b0;
    $display("Test %s finished after %0d commits", name, commit_count);
  endtask

  task automatic build_alu_program();
    clear_images();
    emit(mem_op(cpu_pkg::LW, 1, 0, 0));
    emit(mem_op(cpu_pkg::LW, 2, 0, 1));
    emit(alu_op(cpu_pkg::ADD, 3, 1, 2));
    emit(alu_op(cpu_pkg::SUB, 4, 3, 1));
    emit(alu_op(cpu_pkg::AND, 5, 4, 3));
    emit(alu_op(cpu_pkg::OR, 6, 5, 2));
    emit(alu_op(cpu_pkg::XOR, 7, 6, 4));
    emit(alu_op(cpu_pkg::ADD, 7, 7, 3));
    emit(alu_op(cpu_pkg::SUB, 8, 7, 7));
    emit(alu_op(cpu_pkg::OR, 0, 1, 2)); // r0 stays zero
    emit(alu_op(cpu_pkg::ADD, 9, 0, 7));
    emit(alu_op(cpu_pkg::XOR, 10, 9, 1));
    emit(HALT);
  endtask

  task automatic build_mem_program();
    clear_images();
    data_img[0] = 32'd100; // Base pointer
    emit(mem_op(cpu_pkg::LW, 4, 0, 0));
    emit(mem_op(cpu_pkg::LW, 1, 0, 5));
    emit(alu_op(cpu_pkg::ADD, 2, 1, 1));
    emit(mem_op(cpu_pkg::SW, 2, 4, -3));
    emit(mem_op(cpu_pkg::LW, 5, 4, -3));
    emit(alu_op(cpu_pkg::ADD, 6, 5, 1));
    emit(mem_op(cpu_pkg::LW, 7, 0, 6));
    emit(mem_op(cpu_pkg::SW, 7, 4, 7)); // Store data from a fresh load
    emit(mem_op(cpu_pkg::LW, 8, 4, 7));
    emit(alu_op(cpu_pkg::SUB, 9, 8, 7));
    emit(mem_op(cpu_pkg::SW, 9, 0, -100));
    emit(mem_op(cpu_pkg::LW, 10, 0, -100));
    emit(alu_op(cpu_pkg::XOR, 11, 10, 9));
    emit(HALT);
  endtask

  task automatic build_branch_program();
    logic [31:0] poison;
    clear_images();
    poison      = alu_op(cpu_pkg::ADD, 9, 1, 1);
    data_img[0] = 32'd5;
    data_img[1] = -32'sd3;
    data_img[2] = 32'd5;
    emit(mem_op(cpu_pkg::LW, 1, 0, 0));
    emit(mem_op(cpu_pkg::LW, 2, 0, 1));
    emit(mem_op(cpu_pkg::LW, 3, 0, 2));
    emit(br_op(cpu_pkg::BEQ, 1, 3, 2));
    emit(poison);
    emit(br_op(cpu_pkg::BNE, 1, 3, 2));
    emit(alu_op(cpu_pkg::ADD, 4, 1, 1));
    emit(br_op(cpu_pkg::BLT, 2, 1, 2)); // Signed compare, -3 < 5
    emit(poison);
    emit(br_op(cpu_pkg::BGE, 2, 1, 2));
    emit(alu_op(cpu_pkg::ADD, 5, 2, 1));
    emit(br_op(cpu_pkg::BGE, 1, 2, 2));
    emit(poison);
    emit(br_op(cpu_pkg::BLT, 1, 2, 2));
    emit(alu_op(cpu_pkg::SUB, 6, 1, 2));
    emit(br_op(cpu_pkg::BNE, 1, 2, 3));
    emit(poison);
    emit(poison);
    emit(br_op(cpu_pkg::BEQ, 1, 2, 2));
    emit(alu_op(cpu_pkg::XOR, 7, 1, 2));
    emit(br_op(cpu_pkg::BGE, 1, 3, 2));
    emit(poison);
    emit(HALT);
  endtask

  task automatic build_jump_program();
    clear_images();
    data_img[3] = DEPTH + 600; // Target wraps to 600
    emit(mem_op(cpu_pkg::LW, 1, 0, 3));
    emit({13'd0, 5'd1, 5'd0, 5'd0, 4'(cpu_pkg::JMP)});
    emit(alu_op(cpu_pkg::ADD, 9, 1, 1));
    emit(alu_op(cpu_pkg::ADD, 9, 1, 1));
    org(600);
    emit(alu_op(4'd5, 2, 1, 1));
    emit(alu_op(4'd6, 3, 1, 1));
    emit(alu_op(4'd14, 4, 1, 1));
    emit(alu_op(4'd15, 5, 1, 1));
    emit(alu_op(cpu_pkg::ADD, 6, 1, 1));
    emit(HALT);
  endtask

  task automatic build_random_program();
    int         kind;
    int         boff;
    int         off;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rd;
    clear_images();
    for (int i = 0; i < RANDOM_LEN; i++) begin
      kind = $urandom % 8;
      ra   = 5'($urandom % 32);
      rb   = 5'($urandom % 32);
      rd   = 5'($urandom % 32);
      off  = int'($urandom % 64) - 32;
      if (kind < 4) begin
        emit(alu_op(random_alu_op(), rd, ra, rb));
      end else if (kind < 6) begin
        emit(mem_op(cpu_pkg::LW, rd, rb, off));
      end else if (kind == 6) begin
        emit(mem_op(cpu_pkg::SW, rd, rb, off));
      end else begin
        boff = 1 + $urandom % 4;
        if (i + boff > RANDOM_LEN) begin
          boff = RANDOM_LEN - i; // Never past the halt
        end
        emit(br_op(4'(9 + $urandom % 4), ra, rb, boff));
      end
    end
    emit(HALT);
  endtask

  initial begin
    rst         = 1'b0;
    run_i       = 1'b0;
    load_we_i   = 1'b0;
    load_dmem_i = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    checking    = 1'b0;
    error_count = 0;
    void'($urandom(32));
    build_alu_program();
    run_program("alu");
    build_mem_program();
    run_program("memory");
    build_branch_program();
    run_program("branch");
    build_jump_program();
    run_program("jump");
    build_random_program();
    run_program("random");
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               run_i,
  input  logic                               load_we_i,
  input  logic                               load_dmem_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     load_addr_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     load_data_i,
  output logic                               commit_valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     commit_pc_o,
  output logic [cpu_pkg::INSTR_WIDTH-1:0]    commit_instr_o,
  output logic                               commit_rd_we_o,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] commit_rd_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     commit_rd_data_o,
  output logic                               commit_st_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     commit_st_addr_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     commit_st_data_o
);

  logic                               if_valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0]     if_pc;
  cpu_pkg::instruction_t              if_instr;
  cpu_pkg::if_id_t                    if_id_d;
  cpu_pkg::if_id_t                    if_id_q;
  logic                               if_id_valid;
  cpu_pkg::id_ex_t                    id_ex_d;
  cpu_pkg::id_ex_t                    id_ex_q;
  logic                               id_ex_valid;
  cpu_pkg::ex_wb_t                    ex_wb_d;
  cpu_pkg::ex_wb_t                    ex_wb_q;
  logic                               ex_wb_valid;
  logic                               stall;
  logic                               bubble;
  logic                               flush;
  logic                               redirect;
  logic [cpu_pkg::ADDR_WIDTH-1:0]     redirect_pc;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs1;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs2;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs3;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rd1;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rd2;
  logic [cpu_pkg::DATA_WIDTH-1:0]     rd3;
  logic [cpu_pkg::ADDR_WIDTH-1:0]     imem_addr;
  logic [cpu_pkg::DATA_WIDTH-1:0]     imem_rdata;
  logic                               dmem_we;
  logic [cpu_pkg::ADDR_WIDTH-1:0]     dmem_waddr;
  logic [cpu_pkg::DATA_WIDTH-1:0]     dmem_wdata;
  logic [cpu_pkg::DATA_WIDTH-1:0]     dmem_rdata;

  dmem_if dmem_bus ();

  fetch_unit i_fetch (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_addr_o   (imem_addr),
    .imem_rdata_i  (imem_rdata),
    .if_valid_o    (if_valid),
    .if_pc_o       (if_pc),
    .if_instr_o    (if_instr)
  );

  assign if_id_d = '{pc: if_pc, instr: if_instr};

  stage_reg #(.payload_t(cpu_pkg::if_id_t)) i_if_id (
    .clk     (clk),
    .rst     (rst),
    .stall_i (stall),
    .flush_i (flush),
    .valid_i (if_valid),
    .data_i  (if_id_d),
    .valid_o (if_id_valid),
    .data_o  (if_id_q)
  );

  decode_unit i_decode (
    .if_id_i  (if_id_q),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rs3_o    (rs3),
    .rd1_i    (rd1),
    .rd2_i    (rd2),
    .rd3_i    (rd3),
    .fwd_ex_i (ex_wb_q),
    .id_ex_o  (id_ex_d)
  );

  reg_file i_reg_file (
    .clk   (clk),
    .rst   (rst),
    .rs1_i (rs1),
    .rs2_i (rs2),
    .rs3_i (rs3),
    .rd1_o (rd1),
    .rd2_o (rd2),
    .rd3_o (rd3),
    .we_i  (ex_wb_valid & ex_wb_q.rd_we),
    .wa_i  (ex_wb_q.rd),
    .wd_i  (ex_wb_q.result)
  );

  stage_reg #(.payload_t(cpu_pkg::id_ex_t)) i_id_ex (
    .clk     (clk),
    .rst     (rst),
    .stall_i (1'b0),
    .flush_i (flush | bubble), // Bubble on load-use
    .valid_i (if_id_valid),
    .data_i  (id_ex_d),
    .valid_o (id_ex_valid),
    .data_o  (id_ex_q)
  );

  execute_unit i_execute (
    .id_ex_i       (id_ex_q),
    .valid_i       (id_ex_valid),
    .fwd_wb_i      (ex_wb_q),
    .dmem          (dmem_bus.master),
    .ex_wb_o       (ex_wb_d),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

  hazard_unit i_hazard (
    .if_id_i       (if_id_q),
    .id_ex_i       (id_ex_q),
    .id_ex_valid_i (id_ex_valid),
    .redirect_i    (redirect),
    .stall_o       (stall),
    .bubble_o      (bubble),
    .flush_o       (flush)
  );

  stage_reg #(.payload_t(cpu_pkg::ex_wb_t)) i_ex_wb (
    .clk     (clk),
    .rst     (rst),
    .stall_i (1'b0),
    .flush_i (1'b0),
    .valid_i (id_ex_valid),
    .data_i  (ex_wb_d),
    .valid_o (ex_wb_valid),
    .data_o  (ex_wb_q)
  );

  word_mem #(.DEPTH(cpu_pkg::MEM_DEPTH)) i_imem (
    .clk     (clk),
    .we_i    (!run_i && load_we_i && !load_dmem_i),
    .waddr_i (load_addr_i),
    .wdata_i (load_data_i),
    .raddr_i (imem_addr),
    .rdata_o (imem_rdata)
  );

  // Load port owns the dmem write side while stopped
  assign dmem_we    = run_i ? (dmem_bus.req & dmem_bus.we) : (load_we_i & load_dmem_i);
  assign dmem_waddr = run_i ? dmem_bus.addr : load_addr_i;
  assign dmem_wdata = run_i ? dmem_bus.wdata : load_data_i;

  assign dmem_bus.rdata = dmem_rdata;

  word_mem #(.DEPTH(cpu_pkg::MEM_DEPTH)) i_dmem (
    .clk     (clk),
    .we_i    (dmem_we),
    .waddr_i (dmem_waddr),
    .wdata_i (dmem_wdata),
    .raddr_i (dmem_bus.addr),
    .rdata_o (dmem_rdata)
  );

  assign commit_valid_o   = ex_wb_valid;
  assign commit_pc_o      = ex_wb_q.pc;
  assign commit_instr_o   = ex_wb_q.instr;
  assign commit_rd_we_o   = ex_wb_q.rd_we;
  assign commit_rd_o      = ex_wb_q.rd;
  assign commit_rd_data_o = ex_wb_q.result;
  assign commit_st_o      = ex_wb_q.st_we;
  assign commit_st_addr_o = ex_wb_q.st_addr;
  assign commit_st_data_o = ex_wb_q.st_data;

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int MEM_DEPTH      = 1024;
  localparam int ADDR_WIDTH     = 10;
  localparam int REG_COUNT      = 32;
  localparam int REG_ADDR_WIDTH = 5;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    LW  = 4'd1,
    SW  = 4'd2,
    SUB = 4'd3,
    AND = 4'd4,
    MUL = 4'd5,
    DIV = 4'd6,
    OR  = 4'd7,
    XOR = 4'd8,
    BEQ = 4'd9,
    BNE = 4'd10,
    BLT = 4'd11,
    BGE = 4'd12,
    JMP = 4'd13
  } opcode_t;

  typedef struct packed {
    logic [12:0]               free;
    logic [REG_ADDR_WIDTH-1:0] ra;
    logic [REG_ADDR_WIDTH-1:0] rb;
    logic [REG_ADDR_WIDTH-1:0] rd;
    opcode_t                   opcode;
  } instruction_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    instruction_t          instr;
  } if_id_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    instruction_t          instr;
    logic [DATA_WIDTH-1:0] ra_val;
    logic [DATA_WIDTH-1:0] rb_val;
    logic [DATA_WIDTH-1:0] rd_val; // Store data for SW
    logic [DATA_WIDTH-1:0] off;
    logic [DATA_WIDTH-1:0] boff;
  } id_ex_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]     pc;
    instruction_t              instr;
    logic                      rd_we; // Never set for r0
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     result;
    logic                      st_we;
    logic [ADDR_WIDTH-1:0]     st_addr;
    logic [DATA_WIDTH-1:0]     st_data;
  } ex_wb_t;

  // Operand bypass from the EX/WB register
  function automatic logic [DATA_WIDTH-1:0] fwd_operand(
    ex_wb_t                    wb,
    logic [REG_ADDR_WIDTH-1:0] addr,
    logic [DATA_WIDTH-1:0]     value
  );
    return (wb.rd_we && wb.rd == addr) ? wb.result : value;
  endfunction

endpackage

`default_nettype wire

//--- src/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  cpu_pkg::if_id_t                    if_id_i,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs1_o,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs2_o,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs3_o,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rd1_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rd2_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     rd3_i,
  input  cpu_pkg::ex_wb_t                    fwd_ex_i,
  output cpu_pkg::id_ex_t                    id_ex_o
);

  localparam int OFF_W  = cpu_pkg::INSTR_WIDTH - 14;
  localparam int BOFF_W = 13 + cpu_pkg::REG_ADDR_WIDTH;

  cpu_pkg::instruction_t instr;
  logic [OFF_W-1:0]      off_raw;
  logic [BOFF_W-1:0]     boff_raw;

  assign instr    = if_id_i.instr;
  assign off_raw  = instr[cpu_pkg::INSTR_WIDTH-1:14];
  assign boff_raw = {instr.free, instr.rd};

  assign rs1_o = instr.ra;
  assign rs2_o = instr.rb;
  assign rs3_o = instr.rd; // Store data source

  always_comb begin
    id_ex_o.pc     = if_id_i.pc;
    id_ex_o.instr  = instr;
    // Covers the item retiring from writeback this cycle
    id_ex_o.ra_val = cpu_pkg::fwd_operand(fwd_ex_i, instr.ra, rd1_i);
    id_ex_o.rb_val = cpu_pkg::fwd_operand(fwd_ex_i, instr.rb, rd2_i);
    id_ex_o.rd_val = cpu_pkg::fwd_operand(fwd_ex_i, instr.rd, rd3_i);
    id_ex_o.off    = {{(cpu_pkg::DATA_WIDTH-OFF_W){off_raw[OFF_W-1]}}, off_raw};
    id_ex_o.boff   = {{(cpu_pkg::DATA_WIDTH-BOFF_W){boff_raw[BOFF_W-1]}}, boff_raw};
  end

endmodule

`default_nettype wire

//--- src/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;
  logic                           req;
  logic                           we;
  logic [cpu_pkg::ADDR_WIDTH-1:0] addr;
  logic [cpu_pkg::DATA_WIDTH-1:0] wdata;
  logic [cpu_pkg::DATA_WIDTH-1:0] rdata; // Valid with addr

  modport master (
    output req, we, addr, wdata,
    input  rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata
  );
endinterface

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  cpu_pkg::id_ex_t                id_ex_i,
  input  logic                           valid_i,
  input  cpu_pkg::ex_wb_t                fwd_wb_i,
  dmem_if.master                         dmem,
  output cpu_pkg::ex_wb_t                ex_wb_o,
  output logic                           redirect_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] redirect_pc_o
);

  cpu_pkg::instruction_t          instr;
  logic [cpu_pkg::DATA_WIDTH-1:0] op_a;
  logic [cpu_pkg::DATA_WIDTH-1:0] op_b;
  logic [cpu_pkg::DATA_WIDTH-1:0] op_s;
  logic [cpu_pkg::DATA_WIDTH-1:0] eff_addr;
  logic [cpu_pkg::DATA_WIDTH-1:0] result;
  logic                           is_load;
  logic                           is_store;
  logic                           writes_rd;
  logic                           taken;

  assign instr = id_ex_i.instr;

  assign op_a = cpu_pkg::fwd_operand(fwd_wb_i, instr.ra, id_ex_i.ra_val);
  assign op_b = cpu_pkg::fwd_operand(fwd_wb_i, instr.rb, id_ex_i.rb_val);
  assign op_s = cpu_pkg::fwd_operand(fwd_wb_i, instr.rd, id_ex_i.rd_val);

  assign eff_addr  = op_b + id_ex_i.off;
  assign is_load   = instr.opcode == cpu_pkg::LW;
  assign is_store  = instr.opcode == cpu_pkg::SW;
  assign writes_rd = instr.opcode inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND,
                                          cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::LW};

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (instr.opcode)
      cpu_pkg::ADD: result = op_a + op_b;
      cpu_pkg::SUB: result = op_a - op_b;
      cpu_pkg::AND: result = op_a & op_b;
      cpu_pkg::OR:  result = op_a | op_b;
      cpu_pkg::XOR: result = op_a ^ op_b;
      cpu_pkg::LW:  result = dmem.rdata;
      cpu_pkg::BEQ: taken = op_a == op_b;
      cpu_pkg::BNE: taken = op_a != op_b;
      cpu_pkg::BLT: taken = $signed(op_a) < $signed(op_b);
      cpu_pkg::BGE: taken = $signed(op_a) >= $signed(op_b);
      cpu_pkg::JMP: taken = 1'b1;
      default:      result = '0; // MUL, DIV and reserved act as no-ops
    endcase
  end

  assign redirect_o    = valid_i & taken;
  assign redirect_pc_o = (instr.opcode == cpu_pkg::JMP) ? op_a[cpu_pkg::ADDR_WIDTH-1:0]
                       : id_ex_i.pc + id_ex_i.boff[cpu_pkg::ADDR_WIDTH-1:0];

  assign dmem.req   = valid_i & (is_load | is_store);
  assign dmem.we    = is_store;
  assign dmem.addr  = eff_addr[cpu_pkg::ADDR_WIDTH-1:0];
  assign dmem.wdata = op_s;

  always_comb begin
    ex_wb_o.pc      = id_ex_i.pc;
    ex_wb_o.instr   = instr;
    ex_wb_o.rd_we   = valid_i & writes_rd & (instr.rd != '0);
    ex_wb_o.rd      = instr.rd;
    ex_wb_o.result  = result;
    ex_wb_o.st_we   = valid_i & is_store;
    ex_wb_o.st_addr = eff_addr[cpu_pkg::ADDR_WIDTH-1:0];
    ex_wb_o.st_data = op_s;
  end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           run_i,
  input  logic                           stall_i,
  input  logic                           redirect_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] imem_addr_o,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] imem_rdata_i,
  output logic                           if_valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] if_pc_o,
  output cpu_pkg::instruction_t          if_instr_o
);

  logic [cpu_pkg::ADDR_WIDTH-1:0] pc_q;
  logic [cpu_pkg::ADDR_WIDTH-1:0] pc_d;

  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i; // Redirect wins over stall
    end else if (run_i && !stall_i) begin
      pc_d = pc_q + 1'b1; // Wraps at MEM_DEPTH
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign imem_addr_o = pc_q;
  assign if_valid_o  = run_i;
  assign if_pc_o     = pc_q;
  assign if_instr_o  = cpu_pkg::instruction_t'(imem_rdata_i);

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::if_id_t if_id_i,
  input  cpu_pkg::id_ex_t id_ex_i,
  input  logic            id_ex_valid_i,
  input  logic            redirect_i,
  output logic            stall_o,
  output logic            bubble_o,
  output logic            flush_o
);

  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] load_rd;
  logic                               ex_is_load;
  logic                               id_reads_rd;
  logic                               conflict;

  assign load_rd     = id_ex_i.instr.rd;
  assign ex_is_load  = id_ex_valid_i && id_ex_i.instr.opcode == cpu_pkg::LW;
  assign id_reads_rd = if_id_i.instr.opcode == cpu_pkg::SW; // SW reads rd as data

  assign conflict = load_rd == if_id_i.instr.ra
                 || load_rd == if_id_i.instr.rb
                 || (id_reads_rd && load_rd == if_id_i.instr.rd);

  assign bubble_o = ex_is_load && load_rd != '0 && conflict;
  assign stall_o  = bubble_o && !redirect_i; // Flush overrides stall
  assign flush_o  = redirect_i;

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs1_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs2_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs3_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rd1_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rd2_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rd3_o,
  input  logic                               we_i,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wa_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wd_i
);

  logic [cpu_pkg::DATA_WIDTH-1:0] regs [0:cpu_pkg::REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != '0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // Write-before-read
  assign rd1_o = (rs1_i == '0) ? '0 : (we_i && wa_i == rs1_i) ? wd_i : regs[rs1_i];
  assign rd2_o = (rs2_i == '0) ? '0 : (we_i && wa_i == rs2_i) ? wd_i : regs[rs2_i];
  assign rd3_o = (rs3_i == '0) ? '0 : (we_i && wa_i == rs3_i) ? wd_i : regs[rs3_i];

endmodule

`default_nettype wire

//--- src/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk) begin
    if (!rst || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- src/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
  parameter int DEPTH = 1024
) (
  input  logic                           clk,
  input  logic                           we_i,
  input  logic [$clog2(DEPTH)-1:0]       waddr_i,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic [$clog2(DEPTH)-1:0]       raddr_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0] rdata_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] mem [0:DEPTH-1];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[raddr_i]; // Combinational read

endmodule

`default_nettype wire

//--- vlog.f
src/cpu_pkg.sv
src/dmem_if.sv
src/stage_reg.sv
src/word_mem.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/hazard_unit.sv
src/cpu.sv
sim/tb_cpu.sv
